//--- aq_arbiter.sv
module aq_arbiter (
    input                          clk,
    input  logic                   rst_i,

    input  cache_aq_pkg::aq_req_t  rd_head_i,
    input  cache_aq_pkg::aq_req_t  sw_head_i,
    input  cache_aq_pkg::aq_req_t  wb_head_i,
    input  logic                   rd_empty_i,
    input  logic                   sw_empty_i,
    input  logic                   wb_empty_i,
    output logic                   rd_pop_o,
    output logic                   sw_pop_o,
    output logic                   wb_pop_o,

    input  logic                   bus_req_i,
    input  cache_aq_pkg::aq_req_t  bus_fill_i,
    output logic                   bus_ack_o,

    output logic                   out_req_o,
    input  logic                   out_ack_i,
    output cache_aq_pkg::aq_req_t  out_data_o,
    output cache_aq_pkg::aq_src_e  out_src_o,

    output logic                   bus_pending_o
);

    import cache_aq_pkg::*;

    aq_arb_state_e state;
    aq_src_e       sel_src;
    aq_req_t       sel_req;
    logic          grant;
    logic          release_now;

    // A fill is new until this side has acknowledged it
    assign bus_pending_o = bus_req_i && !bus_ack_o;

    // Fixed priority: bus fill, write-back, read, store-write
    always_comb begin
        sel_src = SRC_NONE;
        sel_req = sw_head_i;
        if (bus_pending_o) begin
            sel_src = SRC_BUS;
            sel_req = bus_fill_i;
        end else if (!wb_empty_i) begin
            sel_src = SRC_WB;
            sel_req = wb_head_i;
        end else if (!rd_empty_i) begin
            sel_src = SRC_RD;
            sel_req = rd_head_i;
        end else if (!sw_empty_i) begin
            sel_src = SRC_SW;
            sel_req = sw_head_i;
        end
    end

    assign grant       = (state == ARB_IDLE) && (sel_src != SRC_NONE);
    assign release_now = (state == ARB_REQ) && out_ack_i;

    // Retire the granted entry on the acknowledging edge
    assign rd_pop_o = release_now && (out_src_o == SRC_RD);
    assign sw_pop_o = release_now && (out_src_o == SRC_SW);
    assign wb_pop_o = release_now && (out_src_o == SRC_WB);

    // Downstream four-phase sequencer
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state     <= ARB_IDLE;
            out_req_o <= 1'b0;
            out_src_o <= SRC_NONE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (grant) begin
                        state     <= ARB_REQ;
                        out_req_o <= 1'b1;
                        out_src_o <= sel_src;
                    end
                end
                ARB_REQ: begin
                    if (out_ack_i) begin  // Consumer took the request
                        state     <= ARB_RELEASE;
                        out_req_o <= 1'b0;
                        out_src_o <= SRC_NONE;
                    end
                end
                ARB_RELEASE: begin
                    if (!out_ack_i) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state     <= ARB_IDLE;
                    out_req_o <= 1'b0;
                    out_src_o <= SRC_NONE;
                end
            endcase
        end
    end

    // Held for the whole downstream transfer
    always_ff @(posedge clk) begin
        if (grant) begin
            out_data_o <= sel_req;
        end
    end

    // Bus fill acknowledge, raised once the fill has been delivered
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus_ack_o <= 1'b0;
        end else if (release_now && (out_src_o == SRC_BUS)) begin
            bus_ack_o <= 1'b1;
        end else if (!bus_req_i) begin
            bus_ack_o <= 1'b0;
        end
    end

endmodule

//--- aq_fifo.sv
`include "cache_aq_defs.svh"

module aq_fifo #(
    parameter int DEPTH = `AQ_DEPTH
) (
    input                          clk,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   req_i,
    output logic                   ack_o,
    input  cache_aq_pkg::aq_req_t  entry_i,
    input  logic                   pop_i,
    output cache_aq_pkg::aq_req_t  head_o,
    output logic                   empty_o,
    output logic                   full_o
);

    import cache_aq_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

    aq_req_t          mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;     // One extra bit to tell full from empty
    logic             do_wr;
    logic             do_rd;

    assign empty_o = (count == '0);
    assign full_o  = (count == FULL_CNT);

    // A new request is taken only once per req_i high phase
    assign do_wr = req_i && !ack_o && !full_o && !flush_i;
    assign do_rd = pop_i && !empty_o;  // Pop on empty is dropped

    assign head_o = mem[rd_ptr];

    // Four-phase enqueue handshake
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else if (do_wr) begin
            ack_o <= 1'b1;
        end else if (!req_i) begin
            ack_o <= 1'b0;  // Producer has released its request
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps naturally
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= entry_i;
        end
    end

endmodule

//--- cache_aq_defs.svh
`ifndef CACHE_AQ_DEFS_SVH
`define CACHE_AQ_DEFS_SVH

// Entries per access queue, keep a power of two
`define AQ_DEPTH 8

// Physical line address carried by each bank half
`define AQ_PADDR_W 15

// Half-line data and byte mask, 16 bytes per bank
`define AQ_LINE_W 128

// Translation info forwarded with loads and stores
`define AQ_PTCINFO_W 128

`endif

//--- cache_aq_pkg.sv
`include "cache_aq_defs.svh"

package cache_aq_pkg;

    // One bank's share of an access
    typedef struct packed {
        logic                    valid;   // Bank takes part in this access
        logic [`AQ_PADDR_W-1:0]  paddr;
        logic [`AQ_LINE_W-1:0]   data;    // Only write-back and fill carry data
        logic [`AQ_LINE_W-1:0]   mask;    // Byte enables
        logic [1:0]              size;
    } aq_half_t;

    // Full request as seen by the cache pipeline
    typedef struct packed {
        aq_half_t                 even;
        aq_half_t                 odd;
        logic [6:0]               ptcid;
        logic [`AQ_PTCINFO_W-1:0] ptcinfo;
        logic [7:0]               qslot;   // Load/store queue slot tag
        logic                     odd_is_greater;
        logic                     need_p1; // Access spills into the next line
        logic [2:0]               onesize;
        logic                     pcd;     // Page cache disable
    } aq_req_t;

    // Who owns the downstream request
    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_SW,
        SRC_RD,
        SRC_WB,
        SRC_BUS
    } aq_src_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_RELEASE
    } aq_arb_state_e;

endpackage

//--- cache_aq_sys.f
+incdir+.
cache_aq_pkg.sv
aq_fifo.sv
aq_arbiter.sv
cache_aq_sys.sv
tb_cache_aq_sys.sv

//--- cache_aq_sys.sv
module cache_aq_sys (
    input                          clk,
    input  logic                   rst_i,

    // Read stage loads
    input  logic                   rd_req_i,
    output logic                   rd_ack_o,
    input  cache_aq_pkg::aq_req_t  rd_entry_i,
    output logic                   rd_full_o,

    // Store stage writes
    input  logic                   sw_req_i,
    output logic                   sw_ack_o,
    input  cache_aq_pkg::aq_req_t  sw_entry_i,
    output logic                   sw_full_o,

    // Dirty-line write-back
    input  logic                   wb_req_i,
    output logic                   wb_ack_o,
    input  cache_aq_pkg::aq_req_t  wb_entry_i,
    output logic                   wb_full_o,

    input  logic                   rdsw_flush_i,
    input  logic                   wb_flush_i,

    // Line fill from the system bus
    input  logic                   bus_req_i,
    input  cache_aq_pkg::aq_req_t  bus_fill_i,
    output logic                   bus_ack_o,

    // Cache pipeline request port
    output logic                   out_req_o,
    input  logic                   out_ack_i,
    output cache_aq_pkg::aq_req_t  out_data_o,
    output cache_aq_pkg::aq_src_e  out_src_o,

    output logic                   all_empty_o
);

    import cache_aq_pkg::*;

    aq_req_t rd_head;
    aq_req_t sw_head;
    aq_req_t wb_head;
    logic    rd_empty;
    logic    sw_empty;
    logic    wb_empty;
    logic    rd_pop;
    logic    sw_pop;
    logic    wb_pop;
    logic    bus_pending;

    aq_fifo rdaq (
        .clk     (clk),          .rst_i  (rst_i),      .flush_i (rdsw_flush_i),
        .req_i   (rd_req_i),     .ack_o  (rd_ack_o),   .entry_i (rd_entry_i),
        .pop_i   (rd_pop),       .head_o (rd_head),
        .empty_o (rd_empty),     .full_o (rd_full_o)
    );

    aq_fifo swaq (
        .clk     (clk),          .rst_i  (rst_i),      .flush_i (rdsw_flush_i),
        .req_i   (sw_req_i),     .ack_o  (sw_ack_o),   .entry_i (sw_entry_i),
        .pop_i   (sw_pop),       .head_o (sw_head),
        .empty_o (sw_empty),     .full_o (sw_full_o)
    );

    aq_fifo wbaq (
        .clk     (clk),          .rst_i  (rst_i),      .flush_i (wb_flush_i),
        .req_i   (wb_req_i),     .ack_o  (wb_ack_o),   .entry_i (wb_entry_i),
        .pop_i   (wb_pop),       .head_o (wb_head),
        .empty_o (wb_empty),     .full_o (wb_full_o)
    );

    aq_arbiter arb (
        .clk           (clk),
        .rst_i         (rst_i),
        .rd_head_i     (rd_head),
        .sw_head_i     (sw_head),
        .wb_head_i     (wb_head),
        .rd_empty_i    (rd_empty),
        .sw_empty_i    (sw_empty),
        .wb_empty_i    (wb_empty),
        .rd_pop_o      (rd_pop),
        .sw_pop_o      (sw_pop),
        .wb_pop_o      (wb_pop),
        .bus_req_i     (bus_req_i),
        .bus_fill_i    (bus_fill_i),
        .bus_ack_o     (bus_ack_o),
        .out_req_o     (out_req_o),
        .out_ack_i     (out_ack_i),
        .out_data_o    (out_data_o),
        .out_src_o     (out_src_o),
        .bus_pending_o (bus_pending)
    );

    // Nothing queued and no fill waiting
    assign all_empty_o = rd_empty & sw_empty & wb_empty & ~bus_pending;

endmodule

//--- tb_cache_aq_sys.sv
`include "cache_aq_defs.svh"

module tb_cache_aq_sys;

    timeunit 1ns;
    timeprecision 100ps;

    import cache_aq_pkg::*;

    localparam int     NUM_TESTS  = 5;
    localparam longint TIMEOUT_NS = NUM_TESTS * 2000 * 20;

    logic    clk = 1'b0;
    logic    rst_i;
    logic    rd_req_i;
    logic    rd_ack_o;
    aq_req_t rd_entry_i;
    logic    rd_full_o;
    logic    sw_req_i;
    logic    sw_ack_o;
    aq_req_t sw_entry_i;
    logic    sw_full_o;
    logic    wb_req_i;
    logic    wb_ack_o;
    aq_req_t wb_entry_i;
    logic    wb_full_o;
    logic    rdsw_flush_i;
    logic    wb_flush_i;
    logic    bus_req_i;
    aq_req_t bus_fill_i;
    logic    bus_ack_o;
    logic    out_req_o;
    logic    out_ack_i;
    aq_req_t out_data_o;
    aq_src_e out_src_o;
    logic    all_empty_o;

    logic    hold_ack;         // Consumer stall
    int      errors;
    int      err_base;
    int      pass_cnt;
    int      fail_cnt;

    aq_req_t model_rd [$];     // Pushed but not yet delivered
    aq_req_t model_sw [$];
    aq_req_t model_wb [$];
    aq_req_t model_bus [$];
    aq_src_e got_src [$];      // Taken by the consumer, not yet checked
    aq_req_t got_data [$];

    cache_aq_sys dut (.*);

    always #10 clk = ~clk;

    task automatic log_error(input string msg);
        errors++;
        $display("Error: %0d ns: %s", $time, msg);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic aq_req_t rand_req();
        logic [$bits(aq_req_t)+31:0] acc;
        acc = '0;
        for (int i = 0; i < ($bits(aq_req_t) + 31) / 32; i++) begin
            acc = {acc[$bits(aq_req_t)-1:0], $urandom};
        end
        return acc[$bits(aq_req_t)-1:0];
    endfunction

    function automatic logic ack_of(input aq_src_e src);
        case (src)
            SRC_RD:  return rd_ack_o;
            SRC_SW:  return sw_ack_o;
            SRC_WB:  return wb_ack_o;
            default: return 1'b0;
        endcase
    endfunction

    task automatic drive_producer(input aq_src_e src, input logic req, input aq_req_t e);
        case (src)
            SRC_RD: begin
                rd_req_i   = req;
                rd_entry_i = e;
            end
            SRC_SW: begin
                sw_req_i   = req;
                sw_entry_i = e;
            end
            default: begin
                wb_req_i   = req;
                wb_entry_i = e;
            end
        endcase
    endtask

    function automatic void record_push(input aq_src_e src, input aq_req_t e);
        case (src)
            SRC_RD:  model_rd.push_back(e);
            SRC_SW:  model_sw.push_back(e);
            default: model_wb.push_back(e);
        endcase
    endfunction

    function automatic logic next_expected(input aq_src_e src, output aq_req_t e);
        e = '0;
        case (src)
            SRC_RD: begin
                if (model_rd.size() == 0) return 1'b0;
                e = model_rd.pop_front();
            end
            SRC_SW: begin
                if (model_sw.size() == 0) return 1'b0;
                e = model_sw.pop_front();
            end
            SRC_WB: begin
                if (model_wb.size() == 0) return 1'b0;
                e = model_wb.pop_front();
            end
            default: begin
                if (model_bus.size() == 0) return 1'b0;
                e = model_bus.pop_front();
            end
        endcase
        return 1'b1;
    endfunction

    // Four-phase enqueue from one producer
    task automatic push_req(input aq_src_e src, input aq_req_t e);
        drive_producer(src, 1'b1, e);
        do next_cycle(); while (!ack_of(src));
        record_push(src, e);
        drive_producer(src, 1'b0, e);
        do next_cycle(); while (ack_of(src));
    endtask

    task automatic raise_bus_fill(input aq_req_t e);
        bus_fill_i = e;
        bus_req_i  = 1'b1;
        model_bus.push_back(e);  // Fill is pending from now on
        do next_cycle(); while (!bus_ack_o);
        bus_req_i = 1'b0;
        do next_cycle(); while (bus_ack_o);
    endtask

    task automatic set_stall(input logic v);
        @(negedge clk);
        hold_ack = v;
        next_cycle();
    endtask

    task automatic expect_delivery(input aq_src_e src);
        aq_src_e got_s;
        aq_req_t got_d;
        aq_req_t exp_d;
        logic    have_exp;
        @(negedge clk);
        while (got_src.size() == 0) @(negedge clk);
        got_s    = got_src.pop_front();
        got_d    = got_data.pop_front();
        have_exp = next_expected(src, exp_d);
        if (got_s != src) begin
            log_error($sformatf("delivery from %s, expected %s", got_s.name(), src.name()));
        end else if (!have_exp) begin
            log_error($sformatf("delivery from %s with nothing pushed", src.name()));
        end else if (got_d != exp_d) begin
            log_error($sformatf("out_data_o from %s differs from the pushed entry", src.name()));
        end
        next_cycle();
    endtask

    // Wait for the system to go quiet, then nothing may be left over
    task automatic settle();
        while (!(all_empty_o && !out_req_o && !out_ack_i)) next_cycle();
        repeat (4) next_cycle();
        if (got_src.size() != 0) begin
            log_error($sformatf("%0d unexpected deliveries", got_src.size()));
            got_src.delete();
            got_data.delete();
        end
        if (model_rd.size() + model_sw.size() + model_wb.size() + model_bus.size() != 0) begin
            log_error("pushed requests were never delivered");
        end
    endtask

    task automatic begin_test();
        err_base = errors;
    endtask

    task automatic close_test(input string name);
        if (errors == err_base) begin
            pass_cnt++;
            $display("%s: passed", name);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", name, errors - err_base);
        end
    endtask

    // Downstream consumer
    initial begin
        forever begin
            next_cycle();
            if (out_ack_i && !out_req_o) begin
                out_ack_i = 1'b0;
            end else if (out_req_o && !out_ack_i && !hold_ack) begin
                got_src.push_back(out_src_o);
                got_data.push_back(out_data_o);
                out_ack_i = 1'b1;
            end
        end
    end

    a_reset_values: assert property (@(posedge clk) $fell(rst_i) |->
        (!out_req_o && !rd_ack_o && !sw_ack_o && !wb_ack_o && !bus_ack_o &&
         !rd_full_o && !sw_full_o && !wb_full_o && all_empty_o))
        else log_error("outputs not at their reset values");

    a_out_stable: assert property (@(posedge clk) disable iff (rst_i)
        (out_req_o && !out_ack_i) |=> ($stable(out_data_o) && $stable(out_src_o)))
        else log_error("out_data_o or out_src_o changed while waiting for out_ack_i");

    a_no_rise_on_ack: assert property (@(posedge clk) disable iff (rst_i)
        (!out_req_o && out_ack_i) |=> !out_req_o)
        else log_error("out_req_o rose while out_ack_i was high");

    a_src_held: assert property (@(posedge clk) disable iff (rst_i)
        out_req_o == (out_src_o != SRC_NONE))
        else log_error("out_src_o does not match whether a request is held");

    a_rd_ack: assert property (@(posedge clk) disable iff (rst_i)
        $rose(rd_ack_o) |-> $past(rd_req_i))
        else log_error("rd_ack_o rose without rd_req_i");

    a_sw_ack: assert property (@(posedge clk) disable iff (rst_i)
        $rose(sw_ack_o) |-> $past(sw_req_i))
        else log_error("sw_ack_o rose without sw_req_i");

    a_wb_ack: assert property (@(posedge clk) disable iff (rst_i)
        $rose(wb_ack_o) |-> $past(wb_req_i))
        else log_error("wb_ack_o rose without wb_req_i");

    a_bus_ack_rise: assert property (@(posedge clk) disable iff (rst_i)
        $rose(bus_ack_o) |-> ($fell(out_req_o) && $past(out_src_o) == SRC_BUS))
        else log_error("bus_ack_o rose without a delivered bus fill");

    a_bus_ack_fall: assert property (@(posedge clk) disable iff (rst_i)
        $fell(bus_ack_o) |-> $past(!bus_req_i))
        else log_error("bus_ack_o fell while bus_req_i was high");

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(88));
        rst_i        = 1'b1;
        rd_req_i     = 1'b0;
        rd_entry_i   = '0;
        sw_req_i     = 1'b0;
        sw_entry_i   = '0;
        wb_req_i     = 1'b0;
        wb_entry_i   = '0;
        rdsw_flush_i = 1'b0;
        wb_flush_i   = 1'b0;
        bus_req_i    = 1'b0;
        bus_fill_i   = '0;
        out_ack_i    = 1'b0;
        hold_ack     = 1'b0;
        errors       = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        repeat (4) @(posedge clk);
        #2;
        rst_i = 1'b0;

        begin_test();
        if (out_req_o !== 1'b0 || rd_ack_o !== 1'b0 || sw_ack_o !== 1'b0 ||
            wb_ack_o !== 1'b0 || bus_ack_o !== 1'b0 || rd_full_o !== 1'b0 ||
            sw_full_o !== 1'b0 || wb_full_o !== 1'b0 || all_empty_o !== 1'b1) begin
            log_error("outputs after reset are not at their reset values");
        end
        push_req(SRC_RD, rand_req());
        expect_delivery(SRC_RD);
        settle();
        close_test("reset and single read");

        begin_test();
        set_stall(1'b1);
        repeat (3) push_req(SRC_WB, rand_req());  // First wb is latched at once
        repeat (3) push_req(SRC_RD, rand_req());
        repeat (3) push_req(SRC_SW, rand_req());
        set_stall(1'b0);
        repeat (3) expect_delivery(SRC_WB);
        repeat (3) expect_delivery(SRC_RD);
        repeat (3) expect_delivery(SRC_SW);
        settle();
        close_test("priority and queue order");

        begin_test();
        set_stall(1'b1);
        repeat (2) push_req(SRC_RD, rand_req());
        repeat (2) push_req(SRC_SW, rand_req());
        fork
            raise_bus_fill(rand_req());
            begin
                repeat (4) begin
                    @(negedge clk);
                    if (bus_ack_o) log_error("bus_ack_o high before the fill was delivered");
                end
                set_stall(1'b0);
                expect_delivery(SRC_RD);   // Already in flight
                expect_delivery(SRC_BUS);
                expect_delivery(SRC_RD);
                repeat (2) expect_delivery(SRC_SW);
            end
        join
        settle();
        close_test("bus fill priority");

        begin_test();
        set_stall(1'b1);
        repeat (`AQ_DEPTH) push_req(SRC_SW, rand_req());
        if (!sw_full_o) log_error("sw_full_o low with the sw queue filled");
        fork
            begin
                push_req(SRC_SW, rand_req());
                if (got_src.size() == 0) begin
                    log_error("push to a full sw queue acknowledged before any delivery");
                end
            end
            begin
                repeat (5) begin
                    @(negedge clk);
                    if (sw_ack_o) log_error("sw_ack_o high while the sw queue is full");
                end
                set_stall(1'b0);
            end
        join
        repeat (`AQ_DEPTH + 1) expect_delivery(SRC_SW);
        settle();
        close_test("full queue back-pressure");

        begin_test();
        set_stall(1'b1);
        repeat (2) push_req(SRC_WB, rand_req());
        repeat (2) push_req(SRC_RD, rand_req());
        repeat (2) push_req(SRC_SW, rand_req());
        rdsw_flush_i = 1'b1;
        next_cycle();
        rdsw_flush_i = 1'b0;
        model_rd.delete();
        model_sw.delete();
        next_cycle();
        if (all_empty_o) log_error("all_empty_o high with wb entries still queued");
        set_stall(1'b0);
        repeat (2) expect_delivery(SRC_WB);
        for (int i = 0; i < 10 && !all_empty_o; i++) begin
            next_cycle();
        end
        if (!all_empty_o) log_error("all_empty_o low after the wb queue drained");
        settle();
        close_test("read/store flush");

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (errors == 0 && fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
